/* eeprom_ctrl.f */
rtl/eeprom_pkg.sv
rtl/bit_link_if.sv
rtl/host_cmd_latch.sv
rtl/eeprom_sequencer.sv
rtl/serial_bit_engine.sv
rtl/eeprom_ctrl.sv
dv/eeprom_model.sv
dv/eeprom_ctrl_tb.sv

/* dv/eeprom_ctrl_tb.sv */
module eeprom_ctrl_tb;

    parameter int HALF_PERIOD = 2;
    localparam int ACK_LIMIT = 4000;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        ack;
    logic        scl;
    wire         sda;
    logic        frame_err;

    logic [7:0]  shadow [0:2047];
    bit          written [0:2047];
    bit          exp_is_read [$];
    logic [7:0]  exp_data [$];
    logic [10:0] exp_addr [$];
    int          reads_issued;
    int          reads_checked;
    logic        ack_last;
    logic [10:0] pool [0:7];
    logic [10:0] addr_pick;

    pullup (sda);

    eeprom_ctrl #(
        .HALF_PERIOD (HALF_PERIOD)
    ) uut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model u_model (
        .scl       (scl),
        .sda       (sda),
        .frame_err (frame_err)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // last byte written to an address, erased value otherwise
    function automatic logic [7:0] expected_read(input logic [10:0] a);
        if (written[a])
            return shadow[a];
        return 8'hff;
    endfunction

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_idle();
        assert ((scl === 1'b1) && (sda === 1'b1) && (ack === 1'b0))
        else
        begin
            $display("Error at %0t: bus not idle, scl=%b sda=%b ack=%b", $time, scl, sda, ack);
            stop_run();
        end
    endtask

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        while (!ack && (cycles < ACK_LIMIT))
        begin
            @(negedge CLK);
            cycles++;
        end
        assert (ack)
        else
        begin
            $display("controller gave no ack within %0d cycles", ACK_LIMIT);
            stop_run();
        end
    endtask

    task automatic start_write(input logic [10:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr      = 1'b1;
        addr    = a;
        wr_data = d;
        exp_is_read.push_back(1'b0);
        exp_data.push_back(8'h00);
        exp_addr.push_back(a);
        shadow[a]  = d;
        written[a] = 1'b1;
        @(negedge CLK);
        wr = 1'b0;
    endtask

    task automatic issue_write(input logic [10:0] a, input logic [7:0] d);
        start_write(a, d);
        wait_ack();
    endtask

    task automatic issue_read(input logic [10:0] a);
        @(negedge CLK);
        rd   = 1'b1;
        addr = a;
        exp_is_read.push_back(1'b1);
        exp_data.push_back(expected_read(a));
        exp_addr.push_back(a);
        reads_issued++;
        @(negedge CLK);
        rd = 1'b0;
        wait_ack();
    endtask

    // compares every ack against the queued request
    always @(negedge CLK)
    begin
        bit          is_read;
        logic [7:0]  want;
        logic [10:0] where;
        if (RESET)
            ack_last = 1'b0;
        else
        begin
            assert (!frame_err)
            else
            begin
                $display("bus model saw a framing failure on scl and sda");
                stop_run();
            end
            if (ack)
            begin
                assert (!ack_last)
                else
                begin
                    $display("Error at %0t: ack high for more than one cycle", $time);
                    stop_run();
                end
                assert (exp_is_read.size() > 0)
                else
                begin
                    $display("ack arrived with no accepted request");
                    stop_run();
                end
                is_read = exp_is_read.pop_front();
                want    = exp_data.pop_front();
                where   = exp_addr.pop_front();
                if (is_read)
                begin
                    assert (rd_data === want)
                    else
                    begin
                        $display("Error at %0t: read of %h gave %h, expected %h",
                            $time, where, rd_data, want);
                        stop_run();
                    end
                    reads_checked++;
                end
            end
            ack_last = ack;
        end
    end

    initial
    begin
        int i;
        RESET         = 1'b1;
        wr            = 1'b0;
        rd            = 1'b0;
        addr          = '0;
        wr_data       = '0;
        reads_issued  = 0;
        reads_checked = 0;
        void'($urandom(32'h1877));

        repeat (16)
        begin
            @(negedge CLK);
            check_idle();
        end
        RESET = 1'b0;
        repeat (20)
        begin
            @(negedge CLK);
            check_idle();
        end

        issue_write(11'h123, 8'h5a);
        issue_read(11'h123);

        // one address in every block, erased before the write
        for (i = 0; i < 8; i++)
        begin
            addr_pick = {3'(i), 8'(i * 37 + 5)};
            issue_read(addr_pick);
            issue_write(addr_pick, 8'(i * 29 + 1));
            issue_read(addr_pick);
        end

        for (i = 0; i < 8; i++)
            pool[i] = 11'($urandom);
        for (i = 0; i < 40; i++)
        begin
            issue_write(pool[$urandom % 8], 8'($urandom));
            issue_read(pool[$urandom % 8]);
        end

        start_write(11'h6c3, 8'h3c);
        repeat (10) @(negedge CLK);
        wr      = 1'b1;     // controller busy, strobe is dropped
        wr_data = 8'hc3;
        @(negedge CLK);
        wr = 1'b0;
        wait_ack();
        issue_read(11'h6c3);

        repeat (10) @(negedge CLK);
        if ((reads_checked == reads_issued) && (exp_is_read.size() == 0))
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d reads were checked", reads_checked, reads_issued);
            stop_run();
        end
    end

endmodule

/* dv/eeprom_model.sv */
module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    output logic frame_err
);

    import eeprom_pkg::*;

    logic [7:0]  mem [0:2047];
    logic        drive_low;
    logic        in_frame;
    logic        repeated;     // start seen with an address already set
    logic        addr_set;
    logic        read_next;
    logic        reading;      // slave is shifting a byte out
    int          bit_idx;
    int          byte_num;
    int          stray_bits;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [2:0]  block;
    logic [10:0] mem_addr;
    ctrl_byte_u  ctrl;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        drive_low  = 1'b0;
        in_frame   = 1'b0;
        repeated   = 1'b0;
        addr_set   = 1'b0;
        read_next  = 1'b0;
        reading    = 1'b0;
        bit_idx    = 0;
        byte_num   = 0;
        stray_bits = 0;
        frame_err  = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;     // erased part
    end

    task automatic report_framing(input string msg);
        $display("eeprom model: framing failure, %s", msg);
        frame_err = 1'b1;
    endtask

    task automatic take_byte();
        if (byte_num == 0)
        begin
            ctrl.raw = shreg;
            if (ctrl.fields.dev_type != DEV_TYPE)
                report_framing("control byte device type is not 1010");
            if (ctrl.fields.rnw)
            begin
                if (!repeated)
                    report_framing("read control byte without a repeated start");
                read_next = 1'b1;
            end
            else
                block = ctrl.fields.block;
        end
        else if (byte_num == 1)
        begin
            mem_addr = {block, shreg};
            addr_set = 1'b1;
        end
        else
            mem[mem_addr] = shreg;
    endtask

    // start, sda falls with scl high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            repeated   = in_frame && addr_set;
            in_frame   = 1'b1;
            bit_idx    = 0;
            byte_num   = 0;
            reading    = 1'b0;
            read_next  = 1'b0;
            stray_bits = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            in_frame = 1'b0;    // stop
            addr_set = 1'b0;
            reading  = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (!in_frame)
        begin
            stray_bits++;       // a start op clocks one of these
            if (stray_bits == 8)
                report_framing("byte clocked without a start condition");
        end
        else if (bit_idx < 8)
        begin
            shreg = {shreg[6:0], (sda !== 1'b0)};
            bit_idx++;
            if ((bit_idx == 8) && !reading)
                take_byte();
        end
        else
        begin
            bit_idx = 0;        // ack slot
            byte_num++;
            if (reading)
                reading = 1'b0; // master nack ends the single read
            else if (read_next)
            begin
                reading   = 1'b1;
                read_next = 1'b0;
                tx        = mem[mem_addr];
            end
        end
    end

    // sda only moves a little after scl falls
    always @(negedge scl)
    begin
        #1;
        if (in_frame && !reading && (bit_idx == 8))
            drive_low = 1'b1;
        else if (reading && (bit_idx < 8))
            drive_low = !tx[7 - bit_idx];
        else
            drive_low = 1'b0;
    end

endmodule

/* rtl/eeprom_ctrl.sv */
module eeprom_ctrl #(
    parameter int HALF_PERIOD = 2
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         wr,
    input  logic                         rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                   wr_data,
    output logic [7:0]                   rd_data,
    output logic                         ack,
    output logic                         scl,
    inout  wire                          sda
);

    logic                         cmd_valid;
    logic                         cmd_read;
    logic [eeprom_pkg::ADDR_W-1:0] cmd_addr;
    logic [7:0]                   cmd_data;
    logic                         seq_finish;
    logic [7:0]                   seq_rd_byte;
    logic                         sda_oe;
    logic                         sda_in;

    bit_link_if link ();

    // open drain, pull-up is off chip
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    host_cmd_latch u_latch (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wr_data     (wr_data),
        .cmd_valid   (cmd_valid),
        .cmd_read    (cmd_read),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .seq_finish  (seq_finish),
        .seq_rd_byte (seq_rd_byte),
        .ack         (ack),
        .rd_data     (rd_data)
    );

    eeprom_sequencer u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_valid   (cmd_valid),
        .cmd_read    (cmd_read),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .seq_finish  (seq_finish),
        .seq_rd_byte (seq_rd_byte),
        .link        (link)
    );

    serial_bit_engine #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_engine (
        .CLK    (CLK),
        .RESET  (RESET),
        .link   (link),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

/* rtl/serial_bit_engine.sv */
module serial_bit_engine #(
    parameter int HALF_PERIOD = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    bit_link_if.engine link,
    output logic       scl,
    output logic       sda_oe,     // high pulls sda low
    input  logic       sda_in
);

    import eeprom_pkg::*;

    localparam int PERIOD = 2 * HALF_PERIOD;
    localparam int CNT_W  = $clog2(PERIOD);
    localparam int MID    = HALF_PERIOD + HALF_PERIOD / 2;   // middle of scl high

    localparam logic [CNT_W-1:0] DATA_PT = '0;                  // scl low
    localparam logic [CNT_W-1:0] COND_PT = CNT_W'(MID - 1);    // start/stop edge
    localparam logic [CNT_W-1:0] SAMP_PT = CNT_W'(MID);
    localparam logic [CNT_W-1:0] LAST_PT = CNT_W'(PERIOD - 1);
    localparam logic [CNT_W-1:0] HIGH_PT = CNT_W'(HALF_PERIOD);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    bus_op_t          op_q;
    logic [7:0]       shift;
    logic             done_q;
    logic             ack_slot;
    logic             last_period;

    // every period is a low half then a high half, idle leaves scl high
    assign scl = !busy || (cnt >= HIGH_PT);

    assign ack_slot    = (bit_cnt == 4'd8);
    assign last_period = (op_q == OP_START) || (op_q == OP_STOP) || ack_slot;

    assign link.done    = done_q;
    assign link.rx_byte = shift;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            sda_oe  <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!busy)
            begin
                if (link.go)
                begin
                    busy    <= 1'b1;
                    cnt     <= '0;
                    bit_cnt <= '0;
                end
            end
            else
            begin
                if (cnt == DATA_PT)
                begin
                    case (op_q)
                        OP_START: sda_oe <= 1'b0;
                        OP_STOP:  sda_oe <= 1'b1;
                        OP_WRITE: sda_oe <= !ack_slot && !shift[7];
                        default:  sda_oe <= 1'b0;   // read bits and nack
                    endcase
                end
                if (cnt == COND_PT)
                begin
                    if (op_q == OP_START)
                        sda_oe <= 1'b1;     // sda falls, scl high
                    else if (op_q == OP_STOP)
                        sda_oe <= 1'b0;     // sda rises, scl high
                end
                if (cnt == LAST_PT)
                begin
                    cnt <= '0;
                    if (last_period)
                    begin
                        busy   <= 1'b0;
                        done_q <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                else
                begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // slave ack in slot 8 is clocked but not looked at
    always_ff @(posedge CLK)
    begin
        if (!busy && link.go)
        begin
            op_q  <= link.op;
            shift <= link.tx_byte;
        end
        else if (busy)
        begin
            if ((op_q == OP_READ) && !ack_slot && (cnt == SAMP_PT))
                shift <= {shift[6:0], sda_in};
            if ((op_q == OP_WRITE) && (cnt == LAST_PT))
                shift <= {shift[6:0], 1'b0};
        end
    end

    // data and ack bits never move sda while scl is high
    a_sda_stable : assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) && !(op_q inside {OP_START, OP_STOP}) |-> !scl);

endmodule

/* rtl/eeprom_sequencer.sv */
module eeprom_sequencer (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         cmd_valid,
    input  logic                         cmd_read,
    input  logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [7:0]                   cmd_data,
    output logic                         seq_finish,
    output logic [7:0]                   seq_rd_byte,
    bit_link_if.sequencer                link
);

    import eeprom_pkg::*;

    seq_state_t state;
    seq_state_t nxt_state;
    logic       issue;
    bus_op_t    nxt_op;
    logic [7:0] nxt_byte;
    ctrl_byte_u ctrl_w;
    ctrl_byte_u ctrl_r;

    always_comb
    begin
        ctrl_w.fields.dev_type = DEV_TYPE;
        ctrl_w.fields.block    = cmd_addr[ADDR_W-1:8];
        ctrl_w.fields.rnw      = 1'b0;
        ctrl_r.fields.dev_type = DEV_TYPE;
        ctrl_r.fields.block    = cmd_addr[ADDR_W-1:8];
        ctrl_r.fields.rnw      = 1'b1;
    end

    // state names the bus operation in flight
    always_comb
    begin
        nxt_state = state;
        issue     = 1'b0;
        nxt_op    = OP_START;
        nxt_byte  = cmd_addr[7:0];
        case (state)
            IDLE:
            begin
                if (cmd_valid)
                begin
                    nxt_state = START;
                    issue     = 1'b1;
                end
            end
            START:
            begin
                if (link.done)
                begin
                    nxt_state = CTRL_W;
                    issue     = 1'b1;
                    nxt_op    = OP_WRITE;
                    nxt_byte  = ctrl_w.raw;
                end
            end
            CTRL_W:
            begin
                if (link.done)
                begin
                    nxt_state = ADDR_LO;
                    issue     = 1'b1;
                    nxt_op    = OP_WRITE;
                end
            end
            ADDR_LO:
            begin
                if (link.done)
                begin
                    issue = 1'b1;
                    if (cmd_read)
                    begin
                        nxt_state = RESTART;    // repeated start, same op code
                    end
                    else
                    begin
                        nxt_state = DATA_W;
                        nxt_op    = OP_WRITE;
                        nxt_byte  = cmd_data;
                    end
                end
            end
            DATA_W:
            begin
                if (link.done)
                begin
                    nxt_state = STOP;
                    issue     = 1'b1;
                    nxt_op    = OP_STOP;
                end
            end
            RESTART:
            begin
                if (link.done)
                begin
                    nxt_state = CTRL_R;
                    issue     = 1'b1;
                    nxt_op    = OP_WRITE;
                    nxt_byte  = ctrl_r.raw;
                end
            end
            CTRL_R:
            begin
                if (link.done)
                begin
                    nxt_state = DATA_R;
                    issue     = 1'b1;
                    nxt_op    = OP_READ;
                end
            end
            DATA_R:
            begin
                if (link.done)
                begin
                    nxt_state = STOP;
                    issue     = 1'b1;
                    nxt_op    = OP_STOP;
                end
            end
            STOP:
            begin
                if (link.done)
                    nxt_state = DONE;
            end
            DONE:
                nxt_state = IDLE;   // lets cmd_valid drop first
            default:
                nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= IDLE;
            link.go    <= 1'b0;
            seq_finish <= 1'b0;
        end
        else
        begin
            state      <= nxt_state;
            link.go    <= issue;
            seq_finish <= (state == STOP) && link.done;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
        begin
            link.op      <= nxt_op;
            link.tx_byte <= nxt_byte;
        end
        if ((state == DATA_R) && link.done)
            seq_rd_byte <= link.rx_byte;
    end

    // no new operation until the engine has reported the last one
    a_go_after_done : assert property (@(posedge CLK) disable iff (RESET)
        link.go |=> (!link.go until_with link.done));

endmodule

/* rtl/host_cmd_latch.sv */
module host_cmd_latch (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         wr,
    input  logic                         rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                   wr_data,
    output logic                         cmd_valid,
    output logic                         cmd_read,
    output logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    output logic [7:0]                   cmd_data,
    input  logic                         seq_finish,
    input  logic [7:0]                   seq_rd_byte,
    output logic                         ack,
    output logic [7:0]                   rd_data
);

    logic accept;

    // strobes while a request is outstanding are dropped
    assign accept = !cmd_valid && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
        end
        else
        begin
            ack <= seq_finish;
            if (seq_finish)
                cmd_valid <= 1'b0;
            else if (accept)
                cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_read <= !wr;            // wr wins over rd
            cmd_addr <= addr;
            cmd_data <= wr_data;
        end
        if (seq_finish && cmd_read)
            rd_data <= seq_rd_byte;     // held until next read
    end

    // ack is a single pulse per transaction
    a_ack_pulse : assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

endmodule

/* rtl/bit_link_if.sv */
interface bit_link_if;

    import eeprom_pkg::*;

    logic       go;         // one-cycle request, engine idle only
    bus_op_t    op;
    logic [7:0] tx_byte;
    logic       done;       // one-cycle, end of operation
    logic [7:0] rx_byte;    // valid from done until next go

    modport sequencer (
        output go,
        output op,
        output tx_byte,
        input  done,
        input  rx_byte
    );

    modport engine (
        input  go,
        input  op,
        input  tx_byte,
        output done,
        output rx_byte
    );

endinterface

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // 2 KB part, eight blocks of 256 bytes
    localparam int ADDR_W = 11;

    localparam logic [3:0] DEV_TYPE = 4'b1010;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bus_op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,     // control byte, write direction
        ADDR_LO,
        DATA_W,
        RESTART,
        CTRL_R,     // control byte, read direction
        DATA_R,
        STOP,
        DONE
    } seq_state_t;

    // control byte sent after every start
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_type;
            logic [2:0] block;      // addr[10:8]
            logic       rnw;
        } fields;
    } ctrl_byte_u;

endpackage
